// File: hw/mem_bus_pkg.sv
//////////////////////////////////////////////////////////////////////
// memory bus types
//////////////////////////////////////////////////////////////////////

package mem_bus_pkg;

    // byte address from the core, only bits 15 to 3 reach a block
    typedef logic [31:0] addr_t;

    // one 64-bit block, the unit of every transfer
    typedef logic [63:0] block_t;

    // memory transaction tag
    // zero means no transaction
    typedef logic [3:0] mem_tag_t;

    // block address, address bits 15 to 3
    typedef logic [12:0] block_addr_t;

    // number of blocks behind the bus
    localparam int mem_blocks = 2 ** $bits(block_addr_t);

    // command sent by the cache, one cycle per access
    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2
    } bus_command_t;

    // block address selected by a byte address
    function automatic block_addr_t block_of(input addr_t addr);
        return addr[15:3];
    endfunction

    // byte address with the in-block offset cleared
    function automatic addr_t block_aligned(input addr_t addr);
        return {addr[31:3], 3'b000};
    endfunction

endpackage

// File: hw/dcache_pkg.sv
//////////////////////////////////////////////////////////////////////
// data cache geometry
//////////////////////////////////////////////////////////////////////

package dcache_pkg;

    // direct-mapped, one block per line
    localparam int cache_lines = 32;

    // line select, low bits of the block address
    typedef logic [4:0] line_index_t;

    // cache tag, high bits of the block address
    // not to be confused with memory transaction tags
    typedef logic [7:0] cache_tag_t;

    // split of a block address into tag and index
    function automatic line_index_t line_index_of(input mem_bus_pkg::block_addr_t block);
        return block[4:0];
    endfunction

    function automatic cache_tag_t cache_tag_of(input mem_bus_pkg::block_addr_t block);
        return block[12:5];
    endfunction

endpackage

// File: hw/mem_tag_pool.sv
//////////////////////////////////////////////////////////////////////
// memory transaction tag allocator
//////////////////////////////////////////////////////////////////////

module mem_tag_pool (
    input  logic                  clock,
    input  logic                  reset,
    // take alloc_tag at this edge
    input  logic                  alloc,
    // nonzero tag freed at this edge
    input  mem_bus_pkg::mem_tag_t release_tag,
    // lowest free tag, zero when none is left
    output mem_bus_pkg::mem_tag_t alloc_tag
);
    import mem_bus_pkg::*;

    // bit i stands for tag i + 1, tag 0 is never handed out
    logic [14:0] free_mask;

    // priority pick from the low end
    always_comb begin
        alloc_tag = '0;
        for (int i = 14; i >= 0; i--) begin
            if (free_mask[i]) begin
                alloc_tag = mem_tag_t'(i + 1);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // all tags free
            free_mask <= '1;
        end else begin
            if (alloc && (alloc_tag != '0)) begin
                free_mask[alloc_tag - 1'b1] <= 1'b0;
            end
            // a returning tag is never the one being taken
            if (release_tag != '0) begin
                free_mask[release_tag - 1'b1] <= 1'b1;
            end
        end
    end

endmodule

// File: hw/dcache.sv
//////////////////////////////////////////////////////////////////////
// blocking write-through data cache
//////////////////////////////////////////////////////////////////////

module dcache (
    input  logic                      clock,
    input  logic                      reset,
    // core load port, level held until the access finishes
    input  logic                      load_en,
    input  mem_bus_pkg::addr_t        load_addr,
    // core store port
    input  logic                      store_en,
    input  mem_bus_pkg::addr_t        store_addr,
    input  mem_bus_pkg::block_t       store_data,
    // answers from memory
    input  mem_bus_pkg::mem_tag_t     mem_response,
    input  mem_bus_pkg::block_t       mem_rdata,
    input  mem_bus_pkg::mem_tag_t     mem_rtag,
    // requests to memory
    output mem_bus_pkg::bus_command_t mem_command,
    output mem_bus_pkg::addr_t        mem_addr,
    output mem_bus_pkg::block_t       mem_wdata,
    // load result
    output mem_bus_pkg::block_t       load_data,
    output logic                      load_valid
);
    import mem_bus_pkg::*;
    import dcache_pkg::*;

    // line storage, only the valid bits carry control state
    logic        line_valid [cache_lines];
    cache_tag_t  line_tag   [cache_lines];
    block_t      line_data  [cache_lines];

    // history for edge and address change detection
    logic        last_load_en;
    logic        last_store_en;
    block_addr_t last_load_block;

    // memory tag of the outstanding miss, zero when idle
    mem_tag_t    pending_tag;

    block_addr_t load_block;
    block_addr_t store_block;
    line_index_t load_index;
    line_index_t store_index;
    cache_tag_t  load_ctag;
    cache_tag_t  store_ctag;

    logic        load_rise;
    logic        store_rise;
    logic        load_hit;
    logic        issue_load;
    logic        addr_changed;
    logic        got_mem_data;

    // line write port, shared by stores and fills
    logic        write_en;
    line_index_t write_index;
    cache_tag_t  write_ctag;
    block_t      write_data;

    //////////////////////////////////////////////////////////////////////
    // address split and lookup
    //////////////////////////////////////////////////////////////////////

    assign load_block  = block_of(load_addr);
    assign store_block = block_of(store_addr);
    assign load_index  = line_index_of(load_block);
    assign load_ctag   = cache_tag_of(load_block);
    assign store_index = line_index_of(store_block);
    assign store_ctag  = cache_tag_of(store_block);

    assign load_hit   = line_valid[load_index] && (line_tag[load_index] == load_ctag);
    // hit answers in the same cycle
    assign load_valid = load_en && load_hit;
    assign load_data  = line_data[load_index];

    //////////////////////////////////////////////////////////////////////
    // bus requests
    //////////////////////////////////////////////////////////////////////

    assign load_rise  = load_en && !last_load_en;
    assign store_rise = store_en && !last_store_en;
    // only a miss on the rising edge goes to memory
    assign issue_load = load_rise && !load_hit;

    always_comb begin
        if (issue_load) begin
            mem_command = bus_load;
        end else if (store_rise) begin
            mem_command = bus_store;
        end else begin
            mem_command = bus_none;
        end
    end

    // store and load never overlap, so the store port picks the address
    assign mem_addr  = store_en ? block_aligned(store_addr) : block_aligned(load_addr);
    // stores are whole blocks, passed through as they come
    assign mem_wdata = store_data;

    // a moved load address abandons the pending return
    assign addr_changed = load_block != last_load_block;
    assign got_mem_data = (pending_tag != '0) && (mem_rtag == pending_tag) && !addr_changed;

    // store writes straight away, otherwise a matching return fills
    assign write_en    = store_rise || got_mem_data;
    assign write_index = store_rise ? store_index : load_index;
    assign write_ctag  = store_rise ? store_ctag : load_ctag;
    assign write_data  = store_rise ? store_data : mem_rdata;

    //////////////////////////////////////////////////////////////////////
    // state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            last_load_en    <= 1'b0;
            last_store_en   <= 1'b0;
            last_load_block <= '1;
            pending_tag     <= '0;
            for (int i = 0; i < cache_lines; i++) begin
                line_valid[i] <= 1'b0;
            end
        end else begin
            last_load_en    <= load_en;
            last_store_en   <= store_en;
            last_load_block <= load_block;
            // memory answers the load with its tag in the issue cycle
            if (issue_load) begin
                pending_tag <= mem_response;
            end else if (got_mem_data || addr_changed || !load_en) begin
                pending_tag <= '0;
            end
            if (write_en) begin
                line_valid[write_index] <= 1'b1;
            end
        end
    end

    // tag and data of a line follow its valid bit
    always_ff @(posedge clock) begin
        if (write_en) begin
            line_tag[write_index]  <= write_ctag;
            line_data[write_index] <= write_data;
        end
    end

endmodule

// File: hw/tagged_memory.sv
//////////////////////////////////////////////////////////////////////
// tagged block memory with fixed latency
//////////////////////////////////////////////////////////////////////

module tagged_memory #(
    // cycles from a load request to its data return, 2 to 14
    parameter int mem_latency = 8
) (
    input  logic                      clock,
    input  logic                      reset,
    // request side
    input  mem_bus_pkg::bus_command_t mem_command,
    input  mem_bus_pkg::addr_t        mem_addr,
    input  mem_bus_pkg::block_t       mem_wdata,
    // tag answer in the request cycle
    output mem_bus_pkg::mem_tag_t     mem_response,
    // data return, marked by its tag
    output mem_bus_pkg::block_t       mem_rdata,
    output mem_bus_pkg::mem_tag_t     mem_rtag
);
    import mem_bus_pkg::*;

    // block storage, contents survive reset
    block_t      storage [mem_blocks];

    // latency pipeline, stage 0 is loaded at the end of the request cycle
    mem_tag_t    stage_tag  [mem_latency];
    block_t      stage_data [mem_latency];

    block_addr_t req_block;
    logic        is_load;
    logic        is_store;

    // tag pool handshake
    logic        alloc;
    mem_tag_t    alloc_tag;

    assign req_block = block_of(mem_addr);
    assign is_load   = mem_command == bus_load;
    assign is_store  = mem_command == bus_store;

    //////////////////////////////////////////////////////////////////////
    // tag handling
    //////////////////////////////////////////////////////////////////////

    assign alloc        = is_load;
    // stores answer with tag 0
    assign mem_response = is_load ? alloc_tag : '0;

    mem_tag_pool i_mem_tag_pool (
        .clock       (clock),
        .reset       (reset),
        .alloc       (alloc),
        .release_tag (mem_rtag),
        .alloc_tag   (alloc_tag)
    );

    //////////////////////////////////////////////////////////////////////
    // storage and return pipeline
    //////////////////////////////////////////////////////////////////////

    // stores take effect at once
    always_ff @(posedge clock) begin
        if (is_store) begin
            storage[req_block] <= mem_wdata;
        end
    end

    // tag stages are control, cleared by reset
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < mem_latency; i++) begin
                stage_tag[i] <= '0;
            end
        end else begin
            stage_tag[0] <= mem_response;
            for (int i = 1; i < mem_latency; i++) begin
                stage_tag[i] <= stage_tag[i - 1];
            end
        end
    end

    // data rides along with its tag
    always_ff @(posedge clock) begin
        stage_data[0] <= storage[req_block];
        for (int i = 1; i < mem_latency; i++) begin
            stage_data[i] <= stage_data[i - 1];
        end
    end

    // last stage lands mem_latency cycles after the request
    assign mem_rtag  = stage_tag[mem_latency - 1];
    assign mem_rdata = stage_data[mem_latency - 1];

endmodule

// File: hw/dcache_subsystem.sv
//////////////////////////////////////////////////////////////////////
// data memory subsystem top
//////////////////////////////////////////////////////////////////////

module dcache_subsystem #(
    // memory return latency in cycles, 2 to 14
    parameter int mem_latency = 8
) (
    input  logic                clock,
    input  logic                reset,
    // core side
    input  logic                load_en,
    input  mem_bus_pkg::addr_t  load_addr,
    input  logic                store_en,
    input  mem_bus_pkg::addr_t  store_addr,
    input  mem_bus_pkg::block_t store_data,
    output mem_bus_pkg::block_t load_data,
    output logic                load_valid
);
    import mem_bus_pkg::*;

    // cache to memory
    bus_command_t mem_command;
    addr_t        mem_addr;
    block_t       mem_wdata;

    // memory to cache
    mem_tag_t     mem_response;
    block_t       mem_rdata;
    mem_tag_t     mem_rtag;

    dcache i_dcache (
        .clock        (clock),
        .reset        (reset),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .store_en     (store_en),
        .store_addr   (store_addr),
        .store_data   (store_data),
        .mem_response (mem_response),
        .mem_rdata    (mem_rdata),
        .mem_rtag     (mem_rtag),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .load_data    (load_data),
        .load_valid   (load_valid)
    );

    tagged_memory #(
        .mem_latency (mem_latency)
    ) i_tagged_memory (
        .clock        (clock),
        .reset        (reset),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_response (mem_response),
        .mem_rdata    (mem_rdata),
        .mem_rtag     (mem_rtag)
    );

endmodule

// File: tb/clock_gen.sv
//////////////////////////////////////////////////////////////////////
// testbench clock and reset
//////////////////////////////////////////////////////////////////////

module clock_gen (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period
    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // power-on reset over the first 4 rising edges
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clock);
        #1 reset = 1'b0;
    end

endmodule

// File: tb/dcache_subsystem_sva.sv
//////////////////////////////////////////////////////////////////////
// memory tag and command rules
//////////////////////////////////////////////////////////////////////

module dcache_subsystem_sva #(
    parameter int mem_latency = 8
) (
    input logic                      clock,
    input logic                      reset,
    input mem_bus_pkg::bus_command_t mem_command,
    input mem_bus_pkg::mem_tag_t     mem_response,
    input mem_bus_pkg::mem_tag_t     mem_rtag,
    input logic                      alloc,
    input mem_bus_pkg::mem_tag_t     alloc_tag
);
    timeunit 1ns;
    timeprecision 100ps;
    import mem_bus_pkg::*;

    // pool cannot run dry with one load per cycle and latency below 15
    alloc_tag_nonzero: assert property (
        @(posedge clock) disable iff (reset) alloc |-> (alloc_tag != '0)
    ) else $error("tag pool gave tag 0 to a load");

    // tag answer comes with every load and with nothing else
    response_on_load: assert property (
        @(posedge clock) disable iff (reset) (mem_response != '0) == (mem_command == bus_load)
    ) else $error("mem_response does not match the bus_load cycles");

    // a return carries the tag of the load mem_latency cycles back
    rtag_after_load: assert property (
        @(posedge clock) disable iff (reset)
        (mem_rtag != '0) |->
            ($past(mem_command, mem_latency) == bus_load) &&
            ($past(mem_response, mem_latency) == mem_rtag)
    ) else $error("mem_rtag without a matching load mem_latency cycles earlier");

endmodule

bind tagged_memory dcache_subsystem_sva #(
    .mem_latency (mem_latency)
) i_dcache_subsystem_sva (
    .clock        (clock),
    .reset        (reset),
    .mem_command  (mem_command),
    .mem_response (mem_response),
    .mem_rtag     (mem_rtag),
    .alloc        (alloc),
    .alloc_tag    (alloc_tag)
);

// File: tb/dcache_subsystem_tb.sv
//////////////////////////////////////////////////////////////////////
// data cache subsystem testbench
//////////////////////////////////////////////////////////////////////

module dcache_subsystem_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import mem_bus_pkg::*;
    import dcache_pkg::*;

    localparam int mem_latency  = 8;
    localparam int random_count = 2000;
    // fill, write-through, overwrite, reset and random phases
    localparam int access_count = 64 * 2 + 8 * 3 + 8 * 3 + 16 + random_count;
    localparam int timeout_ns   = access_count * (mem_latency + 4) * 10 + 1000;

    logic   clock;
    logic   power_reset;
    logic   mid_reset;
    logic   reset;
    logic   load_en;
    addr_t  load_addr;
    logic   store_en;
    addr_t  store_addr;
    block_t store_data;
    block_t load_data;
    logic   load_valid;

    // reference model: memory contents and a shadow of the cache lines
    block_t      mem_model [block_addr_t];
    logic        shadow_valid [cache_lines];
    cache_tag_t  shadow_tag [cache_lines];
    // 16 line indexes times 4 cache tags
    block_addr_t pool [64];

    string test_name;
    int    checks;
    int    block_errors;
    int    latency_errors;
    int    k;
    block_addr_t blk;

    assign reset = power_reset || mid_reset;

    clock_gen i_clock_gen (
        .clock (clock),
        .reset (power_reset)
    );

    dcache_subsystem #(
        .mem_latency (mem_latency)
    ) i_dcache_subsystem (
        .clock      (clock),
        .reset      (reset),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .store_en   (store_en),
        .store_addr (store_addr),
        .store_data (store_data),
        .load_data  (load_data),
        .load_valid (load_valid)
    );

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_block(input string name, input block_t expected, input block_t actual);
        checks++;
        if (actual !== expected) begin
            block_errors++;
            $display("mismatch %s data: expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            latency_errors++;
            $display("mismatch %s latency: expected %0d actual %0d", name, expected, actual);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // access tasks, entered 1 ns after a rising edge
    //////////////////////////////////////////////////////////////////////

    // random upper bits and offset, which the block select ignores
    function automatic addr_t addr_for(input block_addr_t block);
        return {16'($urandom), block, 3'($urandom)};
    endfunction

    function automatic block_t random_data();
        return {$urandom, $urandom};
    endfunction

    task automatic store_block(input block_addr_t block, input block_t data);
        store_addr = addr_for(block);
        store_data = data;
        store_en   = 1'b1;
        @(posedge clock);
        #1 store_en = 1'b0;
        // write-through also fills the line
        mem_model[block]       = data;
        shadow_valid[block[4:0]] = 1'b1;
        shadow_tag[block[4:0]]   = block[12:5];
        @(posedge clock);
        #1;
    endtask

    task automatic load_and_check(input block_addr_t block);
        block_t expected;
        int     expected_cycles;
        int     cycles;
        expected = mem_model[block];
        // hit answers in the enable cycle, a miss after the memory return
        if (shadow_valid[block[4:0]] && (shadow_tag[block[4:0]] == block[12:5])) begin
            expected_cycles = 0;
        end else begin
            expected_cycles = mem_latency + 1;
        end
        load_addr = addr_for(block);
        load_en   = 1'b1;
        cycles    = 0;
        // sample mid cycle where the combinational result is settled
        @(negedge clock);
        while (!load_valid) begin
            cycles++;
            @(negedge clock);
        end
        check_latency(test_name, expected_cycles, cycles);
        check_block(test_name, expected, load_data);
        shadow_valid[block[4:0]] = 1'b1;
        shadow_tag[block[4:0]]   = block[12:5];
        @(posedge clock);
        #1 load_en = 1'b0;
        @(posedge clock);
        #1;
    endtask

    task automatic apply_reset();
        mid_reset = 1'b1;
        repeat (2) @(posedge clock);
        #1 mid_reset = 1'b0;
        for (int i = 0; i < cache_lines; i++) begin
            shadow_valid[i] = 1'b0;
        end
        @(posedge clock);
        #1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h01cf_6763));
        load_en    = 1'b0;
        load_addr  = '0;
        store_en   = 1'b0;
        store_addr = '0;
        store_data = '0;
        mid_reset  = 1'b0;
        checks         = 0;
        block_errors   = 0;
        latency_errors = 0;
        for (int i = 0; i < cache_lines; i++) begin
            shadow_valid[i] = 1'b0;
        end
        // odd lines only, four distinct tags per line
        for (int t = 0; t < 4; t++) begin
            for (int i = 0; i < 16; i++) begin
                pool[t * 16 + i] = {cache_tag_t'(t * 71 + 17), line_index_t'(i * 2 + 1)};
            end
        end
        @(negedge power_reset);
        @(posedge clock);
        #1;

        test_name = "initial_fill";
        for (int i = 0; i < 64; i++) begin
            store_block(pool[i], random_data());
        end
        for (int i = 0; i < 64; i++) begin
            load_and_check(pool[i]);
        end

        // store, evict by a conflicting load, load back from memory
        test_name = "write_through";
        repeat (8) begin
            k = int'($urandom_range(63));
            store_block(pool[k], random_data());
            load_and_check(pool[(k + 16 * (1 + int'($urandom_range(2)))) % 64]);
            load_and_check(pool[k]);
        end

        // store into a cached block, next load must hit
        test_name = "overwrite";
        repeat (8) begin
            blk = pool[$urandom_range(63)];
            load_and_check(blk);
            store_block(blk, random_data());
            load_and_check(blk);
        end

        // every line invalid after reset, memory keeps its blocks
        test_name = "reset";
        apply_reset();
        for (int i = 0; i < 16; i++) begin
            load_and_check(pool[i + 16 * int'($urandom_range(3))]);
        end

        test_name = "random_mix";
        repeat (random_count) begin
            blk = pool[$urandom_range(63)];
            if ($urandom_range(2) == 0) begin
                store_block(blk, random_data());
            end else begin
                load_and_check(blk);
            end
        end

        $display("checks %0d, data errors %0d, latency errors %0d",
                 checks, block_errors, latency_errors);
        if ((block_errors + latency_errors) == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog scaled to the number of accesses
    initial begin
        #(timeout_ns);
        $display("timeout: accesses did not finish within %0d ns", timeout_ns);
        $display("test failed");
        $finish;
    end

endmodule

// File: project.f
hw/mem_bus_pkg.sv
hw/dcache_pkg.sv
hw/mem_tag_pool.sv
hw/dcache.sv
hw/tagged_memory.sv
hw/dcache_subsystem.sv
tb/clock_gen.sv
tb/dcache_subsystem_sva.sv
tb/dcache_subsystem_tb.sv

// File: Makefile
TOP := dcache_subsystem_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

obj_dir/V$(TOP): project.f $(shell cat project.f)
	verilator --binary --assert -j 0 -f project.f --top-module $(TOP)

# failing status when the fail message shows up or the run stops early
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "test failed" sim.log
	grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
